//--- rtl/pipe_pkg.sv
package pipe_pkg;

    typedef logic [31:0] word_t;                 // data and address word
    typedef logic [4:0]  reg_idx_t;              // general register index
    typedef logic [2:0]  credit_cnt_t;           // holds a credit count up to 4

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_PASS
    } alu_op_t;

    localparam int QUEUE_DEPTH = 4;              // queue slots, also the fetch side start credits
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int OUT_CREDITS = 4;              // downstream buffer size

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef struct packed {
        word_t pc_4;                             // address of the next instruction
        word_t instruction;
    } fetch_t;

    typedef struct packed {
        logic       reg_write;
        logic [1:0] mem_control;                 // [0] write, [1] read
        alu_op_t    alu_op;
        logic       immediate;                   // operand 2 is the immediate
        logic       jump;
        logic       branch;
        logic       branch_ne;                   // bne rather than beq
        logic       dest_rt;                     // dest is rt, else rd
    } ctrl_t;

    typedef struct packed {
        logic       no_op;
        word_t      pc_4;
        logic       reg_write;
        logic [1:0] mem_control;
        alu_op_t    alu_op;
        word_t      operand_1;
        word_t      operand_2;
        reg_idx_t   src_1;
        reg_idx_t   src_2;
        reg_idx_t   dest;
        word_t      store_data;                  // rt value for sw
    } ex_ctrl_t;

    typedef struct packed {
        word_t      pc_4;
        reg_idx_t   dest;
        word_t      value;                       // alu result, address for sw
        logic       reg_write;
        logic [1:0] mem_control;
        word_t      store_data;
    } result_t;

    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

//--- rtl/inst_queue.sv
`timescale 1ns/1ps

module inst_queue import pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,                // word from the fetch source
    input  fetch_t      in_fetch,
    input  logic        pop,                     // head taken by decode
    input  logic        flush,                   // redirect, drop everything
    output fetch_t      head,
    output logic        head_valid,
    output credit_cnt_t in_credit_count          // slots freed this cycle
);

    fetch_t                 mem [QUEUE_DEPTH];   // payload only, no reset
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    credit_cnt_t            count;               // occupied slots
    logic                   push;

    assign push       = in_valid & ~flush;       // word in a flush cycle is dropped
    assign head       = mem[rd_ptr];
    assign head_valid = (count != '0);

    // flush returns every occupied slot plus a word dropped this cycle
    assign in_credit_count = flush ? count + credit_cnt_t'(in_valid)
                                   : credit_cnt_t'(pop);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            rd_ptr <= wr_ptr;                    // empty, pointers meet
            count  <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + credit_cnt_t'(push) - credit_cnt_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= in_fetch;
    end

endmodule

//--- rtl/control_unit.sv
`timescale 1ns/1ps

module control_unit import pipe_pkg::*; (
    input  fetch_t head,                         // queue head under decode
    input  word_t  rs_value,
    input  word_t  rt_value,
    output ctrl_t  ctrl,
    output word_t  sign_extend_result,
    output logic   condition_satisfied           // beq/bne condition met
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm;

    assign opcode = head.instruction[31:26];
    assign funct  = head.instruction[5:0];
    assign imm    = head.instruction[15:0];

    assign sign_extend_result  = {{16{imm[15]}}, imm};
    assign condition_satisfied = (rs_value == rt_value) ^ ctrl.branch_ne;

    always_comb begin
        ctrl        = '0;                        // unknown opcode decodes as a no-op
        ctrl.alu_op = ALU_PASS;
        case (opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD:  ctrl.alu_op = ALU_ADD;
                    FN_SUB:  ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: ctrl.reg_write = 1'b0;  // unsupported funct writes nothing
                endcase
            end
            OP_ADDI, OP_ANDI, OP_ORI: begin
                ctrl.reg_write = 1'b1;
                ctrl.immediate = 1'b1;
                ctrl.dest_rt   = 1'b1;
                ctrl.alu_op    = (opcode == OP_ADDI) ? ALU_ADD :
                                 (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
            end
            OP_BEQ, OP_BNE: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = (opcode == OP_BNE);
                ctrl.alu_op    = ALU_SUB;        // rs - rt, record only
            end
            OP_J: begin
                ctrl.jump = 1'b1;                // operand 1 carries the target
            end
            OP_SW: begin
                ctrl.mem_control = 2'b01;        // write
                ctrl.immediate   = 1'b1;
                ctrl.dest_rt     = 1'b1;         // rt names the store source
                ctrl.alu_op      = ALU_ADD;      // base + offset
            end
            default: ;
        endcase
    end

endmodule

//--- rtl/general_reg.sv
`timescale 1ns/1ps

module general_reg import pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t rd_idx_1,                   // rs of the decoded instruction
    input  reg_idx_t rd_idx_2,                   // rt of the decoded instruction
    output word_t    rd_value_1,
    output word_t    rd_value_2,
    input  logic     wr_enable,                  // writeback from ex
    input  reg_idx_t wr_idx,
    input  word_t    wr_value
);

    word_t regs [32];

    // r0 is hard zero, a same-cycle write is bypassed to the reader
    function automatic word_t read_port(input reg_idx_t idx, input word_t stored,
                                        input logic we, input reg_idx_t widx,
                                        input word_t wval);
        if (idx == '0)
            return '0;
        if (we && widx == idx)
            return wval;
        return stored;
    endfunction

    assign rd_value_1 = read_port(rd_idx_1, regs[rd_idx_1], wr_enable, wr_idx, wr_value);
    assign rd_value_2 = read_port(rd_idx_2, regs[rd_idx_2], wr_enable, wr_idx, wr_value);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wr_enable && wr_idx != '0) begin
            regs[wr_idx] <= wr_value;
        end
    end

endmodule

//--- rtl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit import pipe_pkg::*; (
    input  logic      head_valid,                // queue not empty
    input  logic      has_credit,                // ex may issue
    input  redirect_t redirect,                  // branch or jump taken in ex
    output logic      stall,
    output logic      bubble,
    output logic      pop,
    output logic      flush
);

    assign stall  = ~has_credit;                 // ex full, hold id/ex
    assign flush  = redirect.valid;              // wrong path in the queue
    assign bubble = ~head_valid | redirect.valid; // nothing valid to decode
    assign pop    = head_valid & ~stall & ~redirect.valid;

endmodule

//--- rtl/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg import pipe_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,                     // hold, ex cannot issue
    input  logic      bubble,                    // load a no-op
    input  fetch_t    head,                      // instruction under decode
    input  ctrl_t     ctrl,
    input  logic      condition_satisfied,
    input  word_t     reg_1,                     // rs value
    input  word_t     reg_2,                     // rt value
    input  word_t     sign_extend_result,
    output ex_ctrl_t  ex,
    output redirect_t redirect                   // registered branch decision
);

    word_t    jump_target;
    word_t    branch_target;
    reg_idx_t rs;
    reg_idx_t rt;
    reg_idx_t rd;

    assign rs = head.instruction[25:21];
    assign rt = head.instruction[20:16];
    assign rd = head.instruction[15:11];

    assign jump_target   = {head.pc_4[31:28], head.instruction[25:0], 2'b00};
    assign branch_target = head.pc_4 + (sign_extend_result << 2);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex       <= '0;
            ex.no_op <= 1'b1;
            redirect <= '0;
        end else if (stall) begin
            redirect.valid <= 1'b0;              // one cycle only, the rest holds
        end else if (bubble) begin
            ex       <= '0;
            ex.no_op <= 1'b1;
            redirect <= '0;
        end else begin
            ex.no_op       <= 1'b0;
            ex.pc_4        <= head.pc_4;
            ex.reg_write   <= ctrl.reg_write;
            ex.mem_control <= ctrl.mem_control;
            ex.alu_op      <= ctrl.alu_op;
            ex.operand_1   <= ctrl.jump ? jump_target : reg_1;
            ex.operand_2   <= ctrl.immediate ? sign_extend_result : reg_2;
            ex.src_1       <= ctrl.jump ? reg_idx_t'(0) : rs;  // no forwarding onto a target
            ex.src_2       <= ctrl.immediate ? reg_idx_t'(0) : rt;
            ex.dest        <= ctrl.dest_rt ? rt : rd;
            ex.store_data  <= reg_2;

            redirect.valid  <= ctrl.jump | (ctrl.branch & condition_satisfied);
            redirect.target <= ctrl.jump ? jump_target : branch_target;
        end
    end

endmodule

//--- rtl/ex_stage.sv
`timescale 1ns/1ps

module ex_stage import pipe_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  ex_ctrl_t ex,                         // from id/ex register
    input  logic     out_credit,                 // one credit back from downstream
    output logic     has_credit,
    output logic     out_valid,
    output result_t  out_result,
    output logic     wr_enable,                  // writeback port
    output reg_idx_t wr_idx,
    output word_t    wr_value
);

    credit_cnt_t credit_cnt;
    reg_idx_t    last_idx;                       // last written destination
    word_t       last_value;
    word_t       op_1;
    word_t       op_2;
    word_t       store_fwd;
    word_t       alu_result;
    logic        issue;

    function automatic word_t fwd(input reg_idx_t idx, input word_t value,
                                  input reg_idx_t lidx, input word_t lval);
        if (idx != '0 && idx == lidx)
            return lval;                         // read missed the last write
        return value;
    endfunction

    assign op_1      = fwd(ex.src_1, ex.operand_1, last_idx, last_value);
    assign op_2      = fwd(ex.src_2, ex.operand_2, last_idx, last_value);
    assign store_fwd = ex.mem_control[0] ? fwd(ex.dest, ex.store_data, last_idx, last_value)
                                         : ex.store_data;

    always_comb begin
        case (ex.alu_op)
            ALU_ADD: alu_result = op_1 + op_2;
            ALU_SUB: alu_result = op_1 - op_2;
            ALU_AND: alu_result = op_1 & op_2;
            ALU_OR:  alu_result = op_1 | op_2;
            ALU_SLT: alu_result = {31'b0, $signed(op_1) < $signed(op_2)};
            default: alu_result = op_1;          // pass, jump target
        endcase
    end

    assign has_credit = (credit_cnt != '0);
    assign issue      = has_credit & ~ex.no_op;
    assign wr_enable  = issue & ex.reg_write;
    assign wr_idx     = ex.dest;
    assign wr_value   = alu_result;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            credit_cnt <= credit_cnt_t'(OUT_CREDITS);
            out_valid  <= 1'b0;
            last_idx   <= '0;                    // r0 never matches
        end else begin
            case ({out_credit, issue})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: ;                       // both or neither, no change
            endcase
            out_valid <= issue;
            if (wr_enable) last_idx <= wr_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_enable) last_value <= wr_value;
        if (issue) begin
            out_result.pc_4        <= ex.pc_4;
            out_result.dest        <= ex.dest;
            out_result.value       <= alu_result; // address for sw
            out_result.reg_write   <= ex.reg_write;
            out_result.mem_control <= ex.mem_control;
            out_result.store_data  <= store_fwd;
        end
    end

endmodule

//--- rtl/pipe_top.sv
`timescale 1ns/1ps

module pipe_top import pipe_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,                // fetch source side
    input  fetch_t      in_fetch,
    output credit_cnt_t in_credit_count,
    output redirect_t   redirect_out,
    output logic        out_valid,               // memory stage side
    output result_t     out_result,
    input  logic        out_credit
);

    fetch_t   head;
    logic     head_valid;
    logic     pop;
    logic     flush;
    logic     stall;
    logic     bubble;
    logic     has_credit;
    ctrl_t    ctrl;
    word_t    sign_extend_result;
    logic     condition_satisfied;
    word_t    reg_1;
    word_t    reg_2;
    ex_ctrl_t ex;
    logic     wr_enable;
    reg_idx_t wr_idx;
    word_t    wr_value;

    inst_queue u_inst_queue (
        .clk, .rst_n, .in_valid, .in_fetch,
        .pop, .flush, .head, .head_valid, .in_credit_count
    );

    control_unit u_control_unit (
        .head, .rs_value(reg_1), .rt_value(reg_2),
        .ctrl, .sign_extend_result, .condition_satisfied
    );

    general_reg u_general_reg (
        .clk, .rst_n,
        .rd_idx_1  (head.instruction[25:21]),    // rs
        .rd_idx_2  (head.instruction[20:16]),    // rt
        .rd_value_1(reg_1),
        .rd_value_2(reg_2),
        .wr_enable, .wr_idx, .wr_value
    );

    hazard_unit u_hazard_unit (
        .head_valid, .has_credit, .redirect(redirect_out),
        .stall, .bubble, .pop, .flush
    );

    id_ex_reg u_id_ex_reg (
        .clk, .rst_n, .stall, .bubble, .head, .ctrl, .condition_satisfied,
        .reg_1, .reg_2, .sign_extend_result, .ex,
        .redirect(redirect_out)
    );

    ex_stage u_ex_stage (
        .clk, .rst_n, .ex, .out_credit, .has_credit,
        .out_valid, .out_result, .wr_enable, .wr_idx, .wr_value
    );

endmodule

//--- dv/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

word_t     prog_all[$];                          // all programs back to back
int        prog_start[5];
int        prog_size[5];
word_t     arch_regs[32] = '{default: '0};
result_t   exp_rec[$];
word_t     exp_redir[$];
logic [31:0] rng_state = 32'd37583;

function automatic logic [31:0] xorshift();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic int next_delay();
    logic [31:0] r;
    r = xorshift();
    if (r[3:0] == 4'd0)
        return 30 + int'(r[9:4]);                // long withheld span
    return int'(r[5:4]);
endfunction

task automatic check(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        $display("[FAIL] %s got %h expected %h", name, got, exp);
        stop_run("value mismatch");
    end
endtask

function automatic word_t enc_r(input logic [5:0] fn, input int rd, input int rs, input int rt);
    return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic word_t enc_i(input logic [5:0] op, input int rt, input int rs, input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

function automatic void add_prog(input int p, input word_t words[$]);
    prog_start[p] = prog_all.size();
    prog_size[p]  = words.size();
    foreach (words[i]) prog_all.push_back(words[i]);
endfunction

function automatic void build_programs();
    word_t w[$];
    logic [31:0] r;
    logic [5:0] fns[5] = '{FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT};
    logic [5:0] ops[3] = '{OP_ADDI, OP_ANDI, OP_ORI};
    w = '{enc_i(OP_ADDI, 1, 0, 5), enc_i(OP_ADDI, 2, 0, -3), enc_r(FN_ADD, 3, 1, 2),
          enc_r(FN_SUB, 4, 1, 2), enc_r(FN_AND, 5, 1, 2), enc_r(FN_OR, 6, 1, 2),
          enc_r(FN_SLT, 7, 2, 1), enc_r(FN_SLT, 8, 1, 2), enc_i(OP_ANDI, 9, 2, 16'hff0f),
          enc_i(OP_ORI, 10, 0, 16'h8001)};
    add_prog(0, w);
    w = '{enc_i(OP_ADDI, 1, 1, 1), enc_r(FN_ADD, 2, 1, 1), enc_r(FN_SUB, 3, 2, 1),
          enc_r(FN_ADD, 3, 3, 3), enc_r(FN_OR, 4, 3, 2), enc_i(OP_ADDI, 4, 4, -100),
          enc_r(FN_SLT, 5, 4, 3), enc_r(FN_ADD, 6, 5, 4)};
    add_prog(1, w);
    // taken and not-taken branches, a jump, and a branch past the end
    w = '{enc_i(OP_ADDI, 11, 0, 7), enc_i(OP_ADDI, 12, 0, 9), enc_i(OP_BEQ, 11, 11, 1),
          enc_i(OP_ADDI, 13, 0, 1), enc_i(OP_BNE, 11, 11, 3), enc_i(OP_BEQ, 12, 11, 3),
          enc_i(OP_BNE, 12, 11, 1), enc_i(OP_ADDI, 13, 0, 2), {OP_J, 26'd10},
          enc_i(OP_ADDI, 13, 0, 3), enc_r(FN_ADD, 14, 11, 12), enc_i(OP_BNE, 12, 11, 10)};
    add_prog(2, w);
    w = '{enc_i(OP_SW, 3, 1, 8), enc_i(OP_SW, 4, 2, -4)};
    add_prog(3, w);
    w = {};
    for (int k = 0; k < 40; k++) begin
        r = xorshift();
        if (r[2:0] < 3'd4)
            w.push_back(enc_r(fns[r[5:3] % 5], r[9:6], r[13:10], r[17:14]));
        else if (r[2:0] < 3'd7)
            w.push_back(enc_i(ops[r[5:3] % 3], r[9:6], r[13:10], r[31:16]));
        else
            w.push_back(enc_i(OP_SW, r[9:6], r[13:10], r[31:16]));
    end
    add_prog(4, w);
endfunction

// architectural run of one program, appends the expected records and redirects
function automatic void ref_run(input int base, input int len);
    int i;
    int steps;
    word_t ins;
    word_t a;
    word_t b;
    word_t se;
    word_t tgt;
    logic [5:0] op;
    result_t r;
    i = 0;
    steps = 0;
    while (i < len && steps < 1000) begin
        ins = prog_all[base + i];
        op  = ins[31:26];
        a   = arch_regs[ins[25:21]];
        b   = arch_regs[ins[20:16]];
        se  = {{16{ins[15]}}, ins[15:0]};
        r = '0;
        r.pc_4 = word_t'(4 * (i + 1));
        r.dest = ins[15:11];
        r.store_data = b;                        // rt value as read in decode
        r.value = a;
        i++;
        case (op)
            OP_RTYPE: begin
                r.reg_write = 1'b1;
                case (ins[5:0])
                    FN_ADD:  r.value = a + b;
                    FN_SUB:  r.value = a - b;
                    FN_AND:  r.value = a & b;
                    FN_OR:   r.value = a | b;
                    FN_SLT:  r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: r.reg_write = 1'b0;
                endcase
            end
            OP_ADDI, OP_ANDI, OP_ORI: begin
                r.reg_write = 1'b1;
                r.dest = ins[20:16];
                r.value = (op == OP_ADDI) ? a + se : (op == OP_ANDI) ? a & se : a | se;
            end
            OP_BEQ, OP_BNE: begin
                r.value = a - b;
                if ((a == b) != (op == OP_BNE)) begin
                    tgt = r.pc_4 + (se << 2);
                    exp_redir.push_back(tgt);
                    i = int'(tgt >> 2);
                end
            end
            OP_J: begin
                tgt = {r.pc_4[31:28], ins[25:0], 2'b00};
                r.value = tgt;
                exp_redir.push_back(tgt);
                i = int'(tgt >> 2);
            end
            OP_SW: begin
                r.dest = ins[20:16];
                r.mem_control = 2'b01;
                r.value = a + se;                // store address
            end
            default: ;
        endcase
        exp_rec.push_back(r);
        if (r.reg_write && r.dest != 5'd0)
            arch_regs[r.dest] = r.value;
        steps++;
    end
endfunction

`endif

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top import pipe_pkg::*; ();

    logic        clk = 1'b0;
    logic        rst_n = 1'b0;
    logic        in_valid = 1'b0;
    fetch_t      in_fetch = '0;
    logic        out_credit = 1'b0;
    credit_cnt_t in_credit_count;
    redirect_t   redirect_out;
    logic        out_valid;
    result_t     out_result;

    int running = 0;                             // fetch model enabled
    int prog_base = 0;                           // current program inside prog_all
    int prog_len = 0;
    int fetch_pc = 0;                            // word index of the next fetch
    int fetch_credits = QUEUE_DEPTH;
    int rec_count = 0;                           // records seen
    int ret_count = 0;                           // credits handed back downstream
    int credit_delay = 0;
    int cycles = 0;
    int timeout_limit = 1000000;

    pipe_top DUT (
        .clk, .rst_n, .in_valid, .in_fetch, .in_credit_count,
        .redirect_out, .out_valid, .out_result, .out_credit
    );

    always #2 clk = ~clk;                        // 4 ns period

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1);
    endtask

    `include "tb_model.svh"

    // fetch source model with a credit count and a pc that restarts on redirect
    always @(posedge clk) begin
        if (!rst_n) begin
            in_valid      <= 1'b0;
            fetch_credits = QUEUE_DEPTH;
        end else begin
            fetch_credits = fetch_credits + int'(in_credit_count);
            if (fetch_credits > QUEUE_DEPTH)
                stop_run("fetch credits rose above the queue depth");
            if (redirect_out.valid)
                fetch_pc = int'(redirect_out.target >> 2);  // unsent words dropped
            if (running != 0 && fetch_credits > 0 && fetch_pc < prog_len) begin
                in_valid             <= 1'b1;
                in_fetch.pc_4        <= word_t'(4 * (fetch_pc + 1));
                in_fetch.instruction <= prog_all[prog_base + fetch_pc];
                fetch_credits--;
                fetch_pc++;
            end else begin
                in_valid <= 1'b0;
            end
        end
    end

    // downstream buffer returns a credit per record after a random delay
    always @(posedge clk) begin
        if (!rst_n) begin
            out_credit   <= 1'b0;
            credit_delay <= 0;
        end else begin
            out_credit <= 1'b0;
            if (rec_count != ret_count) begin
                if (credit_delay == 0) begin
                    out_credit   <= 1'b1;
                    ret_count    <= ret_count + 1;
                    credit_delay <= next_delay();
                end else begin
                    credit_delay <= credit_delay - 1;
                end
            end
        end
    end

    // compare records and redirects against the reference
    always @(posedge clk) begin
        result_t e;
        if (rst_n && out_valid) begin
            if (exp_rec.size() == 0)
                stop_run("result record with no expected instruction left");
            e = exp_rec.pop_front();
            check("out_result.pc_4", out_result.pc_4, e.pc_4);
            check("out_result.dest", word_t'(out_result.dest), word_t'(e.dest));
            check("out_result.value", out_result.value, e.value);
            check("out_result.reg_write", word_t'(out_result.reg_write), word_t'(e.reg_write));
            check("out_result.mem_control", word_t'(out_result.mem_control),
                  word_t'(e.mem_control));
            check("out_result.store_data", out_result.store_data, e.store_data);
            if (rec_count + 1 - ret_count > OUT_CREDITS)
                stop_run("more records than output credits allow");
            rec_count <= rec_count + 1;
        end
        if (rst_n && redirect_out.valid) begin
            if (exp_redir.size() == 0)
                stop_run("redirect raised with no taken branch or jump expected");
            check("redirect_out.target", redirect_out.target, exp_redir.pop_front());
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > timeout_limit)
            stop_run("timeout, the pipeline stopped making progress");
    end

    initial begin
        build_programs();
        timeout_limit = prog_all.size() * 20 + 16;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int p = 0; p < 5; p++) begin
            @(negedge clk);
            prog_base = prog_start[p];
            prog_len  = prog_size[p];
            fetch_pc  = 0;
            ref_run(prog_base, prog_len);        // registers carry over between programs
            running   = 1;
            @(negedge clk);
            while (!(exp_rec.size() == 0 && exp_redir.size() == 0 &&
                     fetch_credits == QUEUE_DEPTH && rec_count == ret_count))
                @(negedge clk);
            running = 0;
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

//--- build.f
+incdir+dv
rtl/pipe_pkg.sv
rtl/inst_queue.sv
rtl/control_unit.sv
rtl/general_reg.sv
rtl/hazard_unit.sv
rtl/id_ex_reg.sv
rtl/ex_stage.sv
rtl/pipe_top.sv
dv/tb_top.sv

//--- run.sh
#!/bin/sh
# compile and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_top -f build.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed!"; then
    exit 0
fi
exit 1
